//--- verilog/fpu_config.svh
`ifndef FPU_CONFIG_SVH
`define FPU_CONFIG_SVH

// Rounding mode codes as carried in the RISC-V frm field
`define FRM_RNE 3'b000  // Nearest with ties to even
`define FRM_RTZ 3'b001  // Toward zero
`define FRM_RDN 3'b010  // Toward minus infinity
`define FRM_RUP 3'b011  // Toward plus infinity
`define FRM_RMM 3'b100  // Nearest with ties away from zero
// Codes 5 to 7 are reserved and raise NV

// Binary32 field layout
`define FP_EXP_W 8             // Biased exponent width
`define FP_MAN_W 23            // Stored fraction width
`define FP_BIAS  127
`define FP_QNAN  32'h7fc0_0000 // Canonical quiet NaN

`endif

//--- verilog/fpu_pkg.sv
`default_nettype none

`include "fpu_config.svh"

package fpu_pkg;

  typedef logic [`FP_EXP_W+`FP_MAN_W:0]   fp32_t;   // Sign, exponent, fraction
  typedef logic [2:0]                     frm_t;
  typedef logic [4:0]                     fflags_t; // NV DZ OF UF NX from the top bit
  typedef logic [`FP_EXP_W:0]             exp9_t;   // Top bit flags exponent overflow
  typedef logic [`FP_MAN_W-1:0]           man23_t;
  typedef logic [2*(`FP_MAN_W+1)-1:0]     prod_t;   // Two 24-bit significands multiplied

  // Result chosen early for NaN, infinity and zero operands
  typedef struct packed {
    logic  bypass;
    fp32_t result;
    logic  invalid;   // Inf times zero or a signaling NaN
  } special_t;

  typedef struct packed {
    logic                         sign;
    logic signed [`FP_EXP_W+1:0]  exp_sum;  // ea + eb - bias, can go negative
    prod_t                        prod;
    special_t                     special;
    frm_t                         frm;
  } mul_stage_t;

  // Sign, exponent, mantissa, guard and sticky form the 35-bit rounder word
  typedef struct packed {
    logic     sign;
    exp9_t    exp;
    man23_t   man;
    logic     guard;
    logic     sticky;
    special_t special;
    frm_t     frm;
  } pre_round_t;

  typedef struct packed {
    fp32_t a;
    fp32_t b;
    frm_t  frm;
  } fmul_in_t;

  typedef struct packed {
    fp32_t   result;
    fflags_t fflags;
  } fmul_out_t;

endpackage

`default_nettype wire

//--- verilog/fmul_mantissa_stage.sv
`default_nettype none

`include "fpu_config.svh"

module fmul_mantissa_stage import fpu_pkg::*; (
  input  wire             clk,
  input  wire             rst_n,
  input  wire             valid_i,
  output logic            ready_o,
  input  wire fmul_in_t   in_i,
  output logic            valid_o,
  input  wire             ready_i,
  output mul_stage_t      mul_o
);

  // Operand fields
  logic                 a_sign;
  logic                 b_sign;
  logic [`FP_EXP_W-1:0] a_exp;
  logic [`FP_EXP_W-1:0] b_exp;
  man23_t               a_man;
  man23_t               b_man;

  // Operand classes
  logic a_zero;
  logic b_zero;
  logic a_inf;
  logic b_inf;
  logic a_nan;
  logic b_nan;
  logic a_snan;
  logic b_snan;

  logic       sign_d;
  special_t   spec_d;
  mul_stage_t mul_d;
  mul_stage_t mul_q;
  logic       valid_q;

  assign a_sign = in_i.a[`FP_EXP_W+`FP_MAN_W];
  assign b_sign = in_i.b[`FP_EXP_W+`FP_MAN_W];
  assign a_exp  = in_i.a[`FP_MAN_W +: `FP_EXP_W];
  assign b_exp  = in_i.b[`FP_MAN_W +: `FP_EXP_W];
  assign a_man  = in_i.a[`FP_MAN_W-1:0];
  assign b_man  = in_i.b[`FP_MAN_W-1:0];

  // Exponent 0 covers subnormals too, they flush to zero
  assign a_zero = (a_exp == '0);
  assign b_zero = (b_exp == '0);
  assign a_inf  = (&a_exp) && (a_man == '0);
  assign b_inf  = (&b_exp) && (b_man == '0);
  assign a_nan  = (&a_exp) && (a_man != '0);
  assign b_nan  = (&b_exp) && (b_man != '0);
  assign a_snan = a_nan && !a_man[`FP_MAN_W-1];  // Quiet bit clear
  assign b_snan = b_nan && !b_man[`FP_MAN_W-1];

  assign sign_d = a_sign ^ b_sign;

  // Special-case result, priority NaN then inf*0 then inf then zero
  always_comb begin
    spec_d        = '0;
    spec_d.bypass = a_nan | b_nan | a_inf | b_inf | a_zero | b_zero;
    if (a_nan || b_nan) begin
      spec_d.result  = `FP_QNAN;
      spec_d.invalid = a_snan | b_snan;   // Quiet NaN inputs raise nothing
    end else if ((a_inf && b_zero) || (b_inf && a_zero)) begin
      spec_d.result  = `FP_QNAN;
      spec_d.invalid = 1'b1;
    end else if (a_inf || b_inf) begin
      spec_d.result = {sign_d, {`FP_EXP_W{1'b1}}, {`FP_MAN_W{1'b0}}};
    end else begin
      spec_d.result = {sign_d, {(`FP_EXP_W+`FP_MAN_W){1'b0}}};  // Signed zero
    end
  end

  always_comb begin
    mul_d         = '0;
    mul_d.sign    = sign_d;
    // Biased sum keeps a single bias after subtraction
    mul_d.exp_sum = (`FP_EXP_W+2)'(a_exp) + (`FP_EXP_W+2)'(b_exp)
                  - (`FP_EXP_W+2)'(`FP_BIAS);
    mul_d.prod    = {1'b1, a_man} * {1'b1, b_man};  // Hidden bits restored
    mul_d.special = spec_d;
    mul_d.frm     = in_i.frm;
  end

  // Accept when empty or when downstream drains this cycle
  assign ready_o = !valid_q || ready_i;

  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      valid_q <= 1'b0;
      mul_q   <= '0;
    end else if (ready_o) begin
      valid_q <= valid_i;
      if (valid_i) begin
        mul_q <= mul_d;
      end
    end
  end

  assign valid_o = valid_q;
  assign mul_o   = mul_q;

  // Stalled data must hold until the normalize stage takes it
  a_hold_on_stall: assert property (@(posedge clk) disable iff (!rst_n)
    valid_o && !ready_i |=> valid_o && $stable(mul_o));

endmodule

`default_nettype wire

//--- verilog/fmul_normalize.sv
`default_nettype none

`include "fpu_config.svh"

module fmul_normalize import fpu_pkg::*; (
  input  wire              clk,
  input  wire              rst_n,
  input  wire              valid_i,
  output logic             ready_o,
  input  wire mul_stage_t  mul_i,
  output logic             valid_o,
  input  wire              ready_i,
  output pre_round_t       pre_o
);

  localparam int PROD_W  = $bits(prod_t);          // 48
  localparam int GRD_BIT = PROD_W - `FP_MAN_W - 2;  // Bit just below the kept fraction
  localparam int SH_MAX  = 26;                      // Anything further is all sticky

  prod_t                       norm_sig;  // Leading one sits at the top bit
  logic signed [`FP_EXP_W+1:0] norm_exp;
  logic [4:0]                  shamt;
  prod_t                       shifted;
  prod_t                       lost_mask;
  logic                        lost;
  pre_round_t                  pre_d;
  pre_round_t                  pre_q;
  logic                        valid_q;

  // Product of two [1,2) significands lies in [1,4)
  always_comb begin
    if (mul_i.prod[PROD_W-1]) begin
      norm_sig = mul_i.prod;
      norm_exp = mul_i.exp_sum + (`FP_EXP_W+2)'(1);  // Product in [2,4)
    end else begin
      norm_sig = mul_i.prod << 1;
      norm_exp = mul_i.exp_sum;
    end
  end

  // Tiny results need a right shift of 1 - exp to land in subnormal form
  always_comb begin
    if (norm_exp > 0) begin
      shamt = '0;                         // Normal so no denormalization
    end else if (norm_exp < -(SH_MAX - 1)) begin
      shamt = 5'(SH_MAX);                 // Saturate
    end else begin
      shamt = 5'(1 - norm_exp);
    end
  end

  assign shifted   = norm_sig >> shamt;
  assign lost_mask = ~({PROD_W{1'b1}} << shamt);  // Bits that fall off the bottom
  assign lost      = |(norm_sig & lost_mask);

  always_comb begin
    pre_d         = '0;
    pre_d.sign    = mul_i.sign;
    pre_d.exp     = (norm_exp > 0) ? exp9_t'(norm_exp) : '0;  // At most 382
    pre_d.man     = shifted[PROD_W-2 -: `FP_MAN_W];           // Hidden bit dropped
    pre_d.guard   = shifted[GRD_BIT];
    pre_d.sticky  = (|shifted[GRD_BIT-1:0]) | lost;
    pre_d.special = mul_i.special;
    pre_d.frm     = mul_i.frm;
  end

  assign ready_o = !valid_q || ready_i;

  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      valid_q <= 1'b0;
      pre_q   <= '0;
    end else if (ready_o) begin
      valid_q <= valid_i;
      if (valid_i) begin
        pre_q <= pre_d;
      end
    end
  end

  assign valid_o = valid_q;
  assign pre_o   = pre_q;

  // A negative biased sum can never come out with the overflow exponent bit
  a_no_of_from_neg: assert property (@(posedge clk) disable iff (!rst_n)
    valid_i && ready_o && (mul_i.exp_sum < 0) |=> valid_o && !pre_o.exp[`FP_EXP_W]);

endmodule

`default_nettype wire

//--- verilog/fp_round.sv
`default_nettype none

`include "fpu_config.svh"

module fp_round import fpu_pkg::*; (
  input  wire              clk,
  input  wire              rst_n,
  input  wire              valid_i,
  output logic             ready_o,
  input  wire pre_round_t  pre_i,
  output logic             valid_o,
  input  wire              ready_i,
  output fmul_out_t        out_o
);

  localparam exp9_t EXP_MAX = exp9_t'((1 << `FP_EXP_W) - 1);  // 255, all ones

  pre_round_t pre_q;
  logic       valid_q;

  // Truncated and incremented candidates
  logic                  nz;     // Low when the word is subnormal or zero
  logic [`FP_MAN_W+1:0]  m1t;    // Carry, hidden, fraction
  man23_t                m0;
  man23_t                m1;
  exp9_t                 e0;
  exp9_t                 e1;

  logic   last;
  logic   guard;
  logic   sticky;
  logic   inexact;
  logic   inc;
  exp9_t  post_e;
  man23_t post_m;

  logic mode_bad;
  logic nv;
  logic of;
  logic uf;
  logic nx;

  fmul_out_t out_d;

  // Input register loaded on handshake
  assign ready_o = !valid_q || ready_i;

  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      valid_q <= 1'b0;
      pre_q   <= '0;
    end else if (ready_o) begin
      valid_q <= valid_i;
      if (valid_i) begin
        pre_q <= pre_i;
      end
    end
  end

  assign nz  = |pre_q.exp;
  assign m0  = pre_q.man;
  assign e0  = pre_q.exp;
  assign m1t = {1'b0, nz, pre_q.man} + 1'b1;
  // Fraction wraps to zero on mantissa overflow and the exponent takes the carry
  assign m1  = m1t[`FP_MAN_W-1:0];
  assign e1  = pre_q.exp + exp9_t'(m1t[`FP_MAN_W+1] | (m1t[`FP_MAN_W] & ~nz));

  assign last    = pre_q.man[0];
  assign guard   = pre_q.guard;
  assign sticky  = pre_q.sticky;
  assign inexact = guard | sticky;

  always_comb begin
    case (pre_q.frm)
      `FRM_RNE: inc = guard & (last | sticky);  // Tie goes to even
      `FRM_RTZ: inc = 1'b0;
      `FRM_RDN: inc = pre_q.sign & inexact;     // Grow magnitude only when negative
      `FRM_RUP: inc = ~pre_q.sign & inexact;
      `FRM_RMM: inc = guard;
      default:  inc = 1'b0;                     // Reserved code with result replaced below
    endcase
  end

  assign post_e = inc ? e1 : e0;
  assign post_m = inc ? m1 : m0;

  // Flags
  assign mode_bad = (pre_q.frm > `FRM_RMM);
  assign nv       = mode_bad | pre_q.special.invalid;
  assign of       = (post_e >= EXP_MAX);
  assign nx       = inexact | of;
  assign uf       = (post_e == '0) & nx;         // Tiny and inexact

  always_comb begin
    out_d = '0;
    if (nv) begin
      out_d.result = `FP_QNAN;
      out_d.fflags = {nv, 4'b0000};
    end else if (pre_q.special.bypass) begin
      out_d.result = pre_q.special.result;       // Exact, no flags
    end else if (of) begin
      // Signed infinity in every mode
      out_d.result = {pre_q.sign, {`FP_EXP_W{1'b1}}, {`FP_MAN_W{1'b0}}};
      out_d.fflags = {1'b0, 1'b0, of, uf, nx};   // No divide in a multiplier
    end else begin
      out_d.result = {pre_q.sign, post_e[`FP_EXP_W-1:0], post_m};
      out_d.fflags = {1'b0, 1'b0, of, uf, nx};
    end
  end

  assign valid_o = valid_q;
  assign out_o   = out_d;

  // Overflow and underflow exclude each other on any delivered result
  a_of_uf_excl: assert property (@(posedge clk) disable iff (!rst_n)
    valid_o |-> !(out_o.fflags[2] && out_o.fflags[1]));

endmodule

`default_nettype wire

//--- verilog/fmul_top.sv
`default_nettype none

module fmul_top import fpu_pkg::*; (
  input  wire            clk,
  input  wire            rst_n,
  input  wire            in_valid_i,
  output logic           in_ready_o,
  input  wire fmul_in_t  in_i,
  output logic           out_valid_o,
  input  wire            out_ready_i,
  output fmul_out_t      out_o
);

  // Mantissa to normalize
  logic       mul_valid;
  logic       mul_ready;
  mul_stage_t mul_data;

  // Normalize to round
  logic       pre_valid;
  logic       pre_ready;
  pre_round_t pre_data;

  fmul_mantissa_stage fmul_mantissa_stage_inst (
    .clk     (clk),
    .rst_n   (rst_n),
    .valid_i (in_valid_i),
    .ready_o (in_ready_o),
    .in_i    (in_i),
    .valid_o (mul_valid),
    .ready_i (mul_ready),
    .mul_o   (mul_data)
  );

  fmul_normalize fmul_normalize_inst (
    .clk     (clk),
    .rst_n   (rst_n),
    .valid_i (mul_valid),
    .ready_o (mul_ready),
    .mul_i   (mul_data),
    .valid_o (pre_valid),
    .ready_i (pre_ready),
    .pre_o   (pre_data)
  );

  fp_round fp_round_inst (
    .clk     (clk),
    .rst_n   (rst_n),
    .valid_i (pre_valid),
    .ready_o (pre_ready),
    .pre_i   (pre_data),
    .valid_o (out_valid_o),   // Rounding is combinational after this register
    .ready_i (out_ready_i),
    .out_o   (out_o)
  );

endmodule

`default_nettype wire

//--- dv/fmul_model.svh
`ifndef FMUL_MODEL_SVH
`define FMUL_MODEL_SVH

`include "fpu_config.svh"

// Expected product and flags from exact integer significands
// Subnormal inputs count as zero
function automatic fmul_out_t fmul_ref(input fp32_t a, input fp32_t b, input frm_t frm);
  fmul_out_t   r;
  logic        s;
  logic        a_nan;
  logic        b_nan;
  int          ea;
  int          eb;
  int          e;
  int          sh;
  logic [63:0] sig;
  logic [63:0] word;  // Exponent and fraction as one integer so a carry bumps the exponent
  logic        lost;
  logic        g;
  logic        nx;
  logic        up;
  r     = '0;
  s     = a[31] ^ b[31];
  ea    = int'(a[30:23]);
  eb    = int'(b[30:23]);
  a_nan = (ea == 255) && (a[22:0] != '0);
  b_nan = (eb == 255) && (b[22:0] != '0);
  if (frm > `FRM_RMM) begin
    r.result = `FP_QNAN;
    r.fflags = 5'b10000;                                     // Reserved mode
  end else if (a_nan || b_nan) begin
    r.result    = `FP_QNAN;
    r.fflags[4] = (a_nan && !a[22]) || (b_nan && !b[22]);   // Signaling only
  end else if ((ea == 255 && eb == 0) || (ea == 0 && eb == 255)) begin
    r.result = `FP_QNAN;
    r.fflags = 5'b10000;
  end else if (ea == 255 || eb == 255) begin
    r.result = {s, 8'hff, 23'd0};
  end else if (ea == 0 || eb == 0) begin
    r.result = {s, 31'd0};
  end else begin
    sig = 64'({1'b1, a[22:0]}) * 64'({1'b1, b[22:0]});
    e   = ea + eb - `FP_BIAS;
    if (sig[47]) begin
      e = e + 1;
    end else begin
      sig = sig << 1;
    end
    // Leading one at bit 47 now
    lost = 1'b0;
    if (e <= 0) begin
      sh   = 1 - e;                                          // Into subnormal form
      lost = |(sig & ((64'd1 << sh) - 64'd1));
      sig  = sig >> sh;
      e    = 0;
    end
    g    = sig[23];
    nx   = g | lost | (|sig[22:0]);
    word = (64'(e) << 23) | 64'(sig[46:24]);
    case (frm)
      `FRM_RNE: up = g && (sig[24] || lost || (|sig[22:0]));
      `FRM_RTZ: up = 1'b0;
      `FRM_RDN: up = s && nx;
      `FRM_RUP: up = !s && nx;
      default:  up = g;                                      // RMM
    endcase
    word = word + 64'(up);
    if (word >= (64'd255 << 23)) begin
      r.result = {s, 8'hff, 23'd0};                          // Infinity in every mode
      r.fflags = 5'b00101;
    end else begin
      r.result = {s, word[30:0]};
      r.fflags = {3'b000, (word[63:23] == '0) && nx, nx};
    end
  end
  return r;
endfunction

`endif

//--- dv/fmul_tb.sv
`default_nettype none

module fmul_tb import fpu_pkg::*; ();
  timeunit 1ns;
  timeprecision 1ps;

  `include "fmul_model.svh"

  localparam int MAX_CYCLES = 20000;  // Tests take about 9000 cycles

  typedef struct packed {
    fmul_in_t    op;
    logic [31:0] cyc;     // Cycle of the input transfer
    logic        strict;  // Sent with out_ready held high
  } sb_entry_t;

  logic        clk;
  logic        rst_n;
  logic        in_valid;
  logic        in_ready;
  fmul_in_t    in_data;
  logic        out_valid;
  logic        out_ready;
  fmul_out_t   out_data;
  logic [31:0] cycle;
  integer      seed;
  int          errors;
  int          checks;
  logic        bp_mode;     // Random back-pressure
  logic        strict_lat;
  sb_entry_t   sb_q[$];

  fmul_top fmul_top_inst (
    .clk         (clk),
    .rst_n       (rst_n),
    .in_valid_i  (in_valid),
    .in_ready_o  (in_ready),
    .in_i        (in_data),
    .out_valid_o (out_valid),
    .out_ready_i (out_ready),
    .out_o       (out_data)
  );

  initial begin
    clk = 1'b0;
    forever #50 clk = ~clk;
  end

  task automatic check_val(input string name, input logic [31:0] expv,
                           input logic [31:0] actv);
    checks = checks + 1;
    if (expv !== actv) begin
      errors = errors + 1;
      $display("CHECK FAILED %s expected %h got %h", name, expv, actv);
    end
  endtask

  // Scoreboard, sampled before the edge updates the pipeline
  always @(posedge clk) begin
    sb_entry_t ent;
    fmul_out_t exp_out;
    cycle = cycle + 32'd1;
    if (rst_n) begin
      if (in_valid && in_ready) begin
        ent.op     = in_data;
        ent.cyc    = cycle;
        ent.strict = strict_lat;
        sb_q.push_back(ent);
      end
      if (out_valid && out_ready) begin
        if (sb_q.size() == 0) begin
          errors = errors + 1;
          $display("Output transfer at cycle %0d with no input waiting for it", cycle);
        end else begin
          ent     = sb_q.pop_front();
          exp_out = fmul_ref(ent.op.a, ent.op.b, ent.op.frm);
          check_val($sformatf("result (%h x %h frm %0d)", ent.op.a, ent.op.b, ent.op.frm),
                    exp_out.result, out_data.result);
          check_val($sformatf("fflags (%h x %h frm %0d)", ent.op.a, ent.op.b, ent.op.frm),
                    32'(exp_out.fflags), 32'(out_data.fflags));
          if (ent.strict) begin
            check_val("latency", 32'd3, cycle - ent.cyc);
          end
        end
      end
    end
  end

  initial begin
    wait (cycle >= MAX_CYCLES);
    $display("Timeout after %0d cycles with %0d results outstanding", cycle, sb_q.size());
    $display("Checks: %0d  Errors: %0d", checks, errors);
    $display("Regression failed");
    $finish;
  end

  // Called on a falling edge, returns on the falling edge after the transfer
  task automatic send_op(input fp32_t a, input fp32_t b, input frm_t frm);
    logic taken;
    in_valid = 1'b1;
    in_data  = '{a, b, frm};
    taken    = 1'b0;
    while (!taken) begin
      @(posedge clk);
      taken = in_ready;
      @(negedge clk);
      out_ready = bp_mode ? 1'($random(seed)) : 1'b1;
    end
    in_valid = 1'b0;
  endtask

  task automatic send_modes(input fp32_t a, input fp32_t b);
    for (int m = 0; m < 5; m++) begin
      send_op(a, b, frm_t'(m));
    end
  endtask

  task automatic drain();
    in_valid  = 1'b0;
    bp_mode   = 1'b0;
    out_ready = 1'b1;
    while (sb_q.size() != 0) begin
      @(negedge clk);
    end
  endtask

  // Random sign and fraction, exponent in [e_lo, e_lo + e_span)
  function automatic fp32_t rand_fp(input int e_lo, input int e_span);
    logic [31:0] r;
    logic [31:0] e;
    r = $random(seed);
    e = $random(seed);
    return {r[31], 8'(e_lo + int'(e % e_span)), r[22:0]};
  endfunction

  initial begin
    fp32_t ex_a[5];
    fp32_t ex_b[5];
    fp32_t sp_a[11];
    fp32_t sp_b[11];
    seed       = 32'h0fd4_466c;
    errors     = 0;
    checks     = 0;
    cycle      = '0;
    bp_mode    = 1'b0;
    strict_lat = 1'b1;
    rst_n      = 1'b0;
    in_valid   = 1'b0;
    in_data    = '0;
    out_ready  = 1'b1;
    // 3*5, -7*6, 1.5*1.5, 2^10*2^-3, 0.5*-1
    ex_a = '{32'h4040_0000, 32'hc0e0_0000, 32'h3fc0_0000, 32'h4480_0000, 32'h3f00_0000};
    ex_b = '{32'h40a0_0000, 32'h40c0_0000, 32'h3fc0_0000, 32'h3e00_0000, 32'hbf80_0000};
    // qNaN, sNaN, inf*0, inf*finite, zero*finite, subnormal flush, inf*subnormal
    sp_a = '{32'h7fc0_0000, 32'h7f80_0001, 32'hc000_0000, 32'h7f80_0000, 32'h8000_0000,
             32'h7f80_0000, 32'hff80_0000, 32'h0000_0000, 32'h8000_0000, 32'h0000_0001,
             32'h7f80_0000};
    sp_b = '{32'h3f80_0000, 32'h3f80_0000, 32'hff80_0001, 32'h0000_0000, 32'hff80_0000,
             32'hc000_0000, 32'hff80_0000, 32'h4040_0000, 32'h40a0_0000, 32'hc040_0000,
             32'h807f_ffff};
    repeat (3) @(posedge clk);
    @(negedge clk);
    rst_n = 1'b1;
    check_val("in_ready after reset", 32'd1, 32'(in_ready));
    check_val("out_valid after reset", 32'd0, 32'(out_valid));
    for (int i = 0; i < 5; i++) begin
      send_modes(ex_a[i], ex_b[i]);
    end
    for (int m = 0; m < 5; m++) begin
      for (int i = 0; i < 1500; i++) begin
        send_op(rand_fp(64, 128), rand_fp(64, 128), frm_t'(m));
      end
    end
    send_modes(32'h7f00_0000, 32'h4000_0000);   // 2^127 * 2
    send_modes(32'hff7f_ffff, 32'h7f7f_ffff);   // -max * max
    for (int i = 0; i < 200; i++) begin
      send_op(rand_fp(192, 63), rand_fp(192, 63), frm_t'(i % 5));
    end
    send_modes(32'h0d80_0000, 32'h3080_0000);   // Exact 2^-130
    send_modes(32'h3f7f_ffff, 32'h0080_0000);   // Halfway below 2^-126, carry to exp 1
    send_modes(32'h3f7f_ffff, 32'h8080_0000);
    send_modes(32'h0080_0000, 32'h0080_0000);   // Far below the smallest subnormal
    for (int i = 0; i < 500; i++) begin
      send_op(rand_fp(1, 40), rand_fp(70, 60), frm_t'(i % 5));
    end
    for (int i = 0; i < 11; i++) begin
      send_modes(sp_a[i], sp_b[i]);
    end
    for (int m = 5; m < 8; m++) begin
      send_op(32'h4040_0000, 32'h40a0_0000, frm_t'(m));
      send_op(32'h7f80_0000, 32'h3f80_0000, frm_t'(m));
    end
    drain();
    // Order and completeness under back-pressure
    strict_lat = 1'b0;
    bp_mode    = 1'b1;
    for (int i = 0; i < 400; i++) begin
      send_op(rand_fp(64, 128), rand_fp(64, 128), frm_t'(i % 5));
    end
    drain();
    repeat (2) @(negedge clk);
    $display("Checks: %0d  Errors: %0d", checks, errors);
    if (errors == 0) begin
      $display("Regression passed");
    end else begin
      $display("Regression failed");
    end
    $finish;
  end

endmodule

`default_nettype wire

//--- verilog.f
+incdir+verilog
+incdir+dv
verilog/fpu_pkg.sv
verilog/fmul_mantissa_stage.sv
verilog/fmul_normalize.sv
verilog/fp_round.sv
verilog/fmul_top.sv
dv/fmul_tb.sv

//--- run_sim.sh
#!/bin/sh
set -e
cd "$(dirname "$0")"

verilator --binary --timing --assert --top-module fmul_tb -f verilog.f -Mdir obj_dir

out=$(./obj_dir/Vfmul_tb)
printf '%s\n' "$out"

if printf '%s\n' "$out" | grep -qx 'Regression passed'; then
  exit 0
fi
exit 1
